// ==== tracer.f ====
logic/fixedPointPkg.sv
logic/tracerPkg.sv
logic/cameraRegs.sv
logic/reciprocalUnit.sv
logic/gridWalker.sv
logic/traceControl.sv
logic/tracerTop.sv
dv/tracerChecker.sv
dv/tracerTb.sv

// ==== dv/tracerTb.sv ====
`timescale 1ns/1ns

module tracerTb;

  localparam int NumTests = 6;
  localparam int ReadyTimeout = 400;

  // One row of the stimulus table with the result the display should get
  typedef struct packed {
    fixedPointPkg::cameraT camera;
    logic [3:0]            blockCol;
    logic [3:0]            blockRow;
    logic [1:0]            blockId;
    logic [3:0]            lines;
    logic                  earlyStrobe;
    tracerPkg::lineResultT expected;
  } testRowT;

  logic                  clk = 1'b0;
  logic                  do_reset;
  logic                  vsync;
  logic                  hmax;
  logic                  strobeTaken;
  fixedPointPkg::cameraT camera;
  logic [1:0]            mapVal;
  logic [3:0]            mapCol;
  logic [3:0]            mapRow;
  logic                  traceReady;
  tracerPkg::lineResultT line;
  tracerPkg::lineResultT expected;
  logic [3:0]            testId;
  logic [3:0]            lineNum;
  logic                  testEnd;
  logic                  timeout;
  logic                  report;
  int                    errorCount;
  // Tile map indexed by row then column
  logic [15:0][15:0][1:0] mapTable;
  testRowT               testTable [NumTests];

  always #5 clk = ~clk;

  // The map answers in the same cycle, like a combinational tile ROM
  assign mapVal = mapTable[mapRow][mapCol];

  tracerTop DUT (
    .clk         (clk),
    .do_reset    (do_reset),
    .i_vsync     (vsync),
    .i_hmax      (hmax),
    .i_camera    (camera),
    .i_mapVal    (mapVal),
    .o_mapCol    (mapCol),
    .o_mapRow    (mapRow),
    .o_traceReady(traceReady),
    .o_line      (line)
  );

  tracerChecker uChecker (
    .clk          (clk),
    .do_reset     (do_reset),
    .i_hmax       (hmax),
    .i_strobeTaken(strobeTaken),
    .i_traceReady (traceReady),
    .i_line       (line),
    .i_expected   (expected),
    .i_testId     (testId),
    .i_lineNum    (lineNum),
    .i_testEnd    (testEnd),
    .i_timeout    (timeout),
    .i_report     (report),
    .o_errorCount (errorCount)
  );

  // Positions and vectors are given in units of 1/1024
  function automatic fixedPointPkg::cameraT makeCamera(input int px, input int py,
                                                       input int fx, input int fy,
                                                       input int lx, input int ly);
    fixedPointPkg::cameraT cam;
    cam.player.x = fixedPointPkg::fixedT'(px);
    cam.player.y = fixedPointPkg::fixedT'(py);
    cam.facing.x = fixedPointPkg::fixedT'(fx);
    cam.facing.y = fixedPointPkg::fixedT'(fy);
    cam.plane.x = fixedPointPkg::fixedT'(lx);
    cam.plane.y = fixedPointPkg::fixedT'(ly);
    return cam;
  endfunction

  function automatic testRowT makeRow(input fixedPointPkg::cameraT cam, input int col,
                                      input int row, input int id, input int lines,
                                      input bit early, input int wall, input int side,
                                      input int size, input int texU);
    testRowT r;
    r.camera = cam;
    r.blockCol = 4'(col);
    r.blockRow = 4'(row);
    r.blockId = 2'(id);
    r.lines = 4'(lines);
    r.earlyStrobe = early;
    r.expected.wall = 2'(wall);
    r.expected.side = 1'(side);
    r.expected.size = 11'(size);
    r.expected.texU = 6'(texU);
    return r;
  endfunction

  task automatic fillTable();
    // X-side hit at distance 2.5 gives 256 / 2.5 and the centre texel
    testTable[0] = makeRow(makeCamera(2560, 2560, 1024, 0, 0, 0), 5, 2, 2, 1, 0, 2, 0, 102, 32);
    // Y-side hit at distance 3.5, the texel mirrors because the ray runs toward +y
    testTable[1] = makeRow(makeCamera(2560, 2560, 0, 1024, 0, 0), 2, 6, 3, 1, 0, 3, 1, 73, 31);
    // Block boundary at 51/1024 is too near, the border wall at 12339/1024 is hit
    testTable[2] = makeRow(makeCamera(3021, 2560, 1024, 0, 0, 0), 3, 2, 2, 1, 0, 1, 0, 21, 32);
    // Exactly the minimum distance, so 8192 >> 2 clamps to the size limit
    testTable[3] = makeRow(makeCamera(2944, 2560, 1024, 0, 0, 0), 3, 2, 3, 1, 0, 3, 0, 2047, 32);
    // Ray y stays at floor(-1088/256) = -5 for these lines and nudges the texel down
    testTable[4] = makeRow(makeCamera(2560, 2560, 1024, 0, 0, 4), 5, 2, 2, 3, 0, 2, 0, 102, 31);
    // Early strobe must leave the previous line on the output
    testTable[5] = makeRow(makeCamera(2560, 2560, 0, 1024, 0, 0), 2, 6, 3, 1, 1, 3, 1, 73, 31);
  endtask

  // Border walls of id 1 with one extra block inside
  task automatic buildMap(input logic [3:0] col, input logic [3:0] row, input logic [1:0] id);
    for (int r = 0; r < 16; r++) begin
      for (int c = 0; c < 16; c++) begin
        mapTable[r][c] = (r == 0 || r == 15 || c == 0 || c == 15) ? 2'd1 : 2'd0;
      end
    end
    mapTable[row][col] = id;
  endtask

  // Taken marks a strobe sent once the line is ready, so the display takes a new line
  task automatic pulseStrobe(input bit taken);
    hmax = 1'b1;
    strobeTaken = taken;
    @(negedge clk);
    hmax = 1'b0;
    strobeTaken = 1'b0;
  endtask

  task automatic waitReady(output bit ok);
    int cycles;
    cycles = 0;
    ok = 1'b0;
    while (!ok && cycles < ReadyTimeout) begin
      if (traceReady) begin
        ok = 1'b1;
      end else begin
        @(negedge clk);
        cycles++;
      end
    end
  endtask

  task automatic runTest(input int idx);
    testRowT row;
    bit      ok;
    row = testTable[idx];
    testId = 4'(idx + 1);
    lineNum = 4'd0;
    expected = row.expected;
    camera = row.camera;
    buildMap(row.blockCol, row.blockRow, row.blockId);
    // Vsync latches the camera and restarts the first line
    vsync = 1'b1;
    repeat (2) @(negedge clk);
    vsync = 1'b0;
    if (row.earlyStrobe) begin
      pulseStrobe(1'b0);
    end
    ok = 1'b1;
    for (int ln = 1; ln <= row.lines && ok; ln++) begin
      lineNum = 4'(ln);
      waitReady(ok);
      if (ok) begin
        pulseStrobe(1'b1);
      end else begin
        timeout = 1'b1;
        @(negedge clk);
        timeout = 1'b0;
      end
    end
    testEnd = 1'b1;
    @(negedge clk);
    testEnd = 1'b0;
    @(negedge clk);
  endtask

  initial begin
    do_reset = 1'b1;
    vsync = 1'b0;
    hmax = 1'b0;
    strobeTaken = 1'b0;
    camera = '0;
    expected = '0;
    testId = 4'd0;
    lineNum = 4'd0;
    testEnd = 1'b0;
    timeout = 1'b0;
    report = 1'b0;
    fillTable();
    buildMap(4'd0, 4'd0, 2'd1);
    repeat (8) @(posedge clk);
    @(negedge clk);
    do_reset = 1'b0;
    @(negedge clk);
    for (int t = 0; t < NumTests; t++) begin
      runTest(t);
    end
    // Let the checker print its totals before the verdict
    report = 1'b1;
    @(negedge clk);
    report = 1'b0;
    @(negedge clk);
    if (errorCount == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== dv/tracerChecker.sv ====
`timescale 1ns/1ns

module tracerChecker (
  input  logic                  clk,
  input  logic                  do_reset,
  input  logic                  i_hmax,
  input  logic                  i_strobeTaken,
  input  logic                  i_traceReady,
  input  tracerPkg::lineResultT i_line,
  input  tracerPkg::lineResultT i_expected,
  input  logic [3:0]            i_testId,
  input  logic [3:0]            i_lineNum,
  input  logic                  i_testEnd,
  input  logic                  i_timeout,
  input  logic                  i_report,
  output int                    o_errorCount
);

  // Line the display should show, following the strobe and back-pressure rules
  tracerPkg::lineResultT model;
  // Events seen at the rising edge, handled at the falling edge once outputs settle
  logic       strobeSeen;
  logic       acceptSeen;
  logic       readySeen;
  logic       endSeen;
  logic       timeoutSeen;
  logic       reportSeen;
  logic [3:0] curTest;
  logic [3:0] curLine;
  int         checks = 0;
  int         errors = 0;
  int         testChecks = 0;
  int         testErrors = 0;

  assign o_errorCount = errors;

  task automatic compareField(input string name, input int got, input int want);
    if (got != want) begin
      $display("Mismatch %s: got 0x%0h expected 0x%0h (test %0d line %0d)",
               name, got, want, curTest, curLine);
      errors++;
      testErrors++;
    end
  endtask

  always @(posedge clk) begin
    if (do_reset) begin
      model <= '0;
      strobeSeen <= 1'b0;
      acceptSeen <= 1'b0;
      readySeen <= 1'b0;
      endSeen <= 1'b0;
      timeoutSeen <= 1'b0;
      reportSeen <= 1'b0;
    end else begin
      strobeSeen <= i_hmax;
      acceptSeen <= i_hmax && i_strobeTaken;
      readySeen <= i_traceReady;
      // Only a strobe sent after the wait for ready brings in a new line
      if (i_hmax && i_strobeTaken) begin
        model <= i_expected;
      end
      endSeen <= i_testEnd;
      timeoutSeen <= i_timeout;
      reportSeen <= i_report;
    end
    curTest <= i_testId;
    curLine <= i_lineNum;
  end

  always @(negedge clk) begin
    if (strobeSeen) begin
      checks++;
      testChecks++;
      compareField("o_line.wall", i_line.wall, model.wall);
      compareField("o_line.side", i_line.side, model.side);
      compareField("o_line.size", i_line.size, model.size);
      compareField("o_line.texU", i_line.texU, model.texU);
      // A strobe sent straight after vsync has to find the tracer still busy
      if (!acceptSeen && readySeen) begin
        $display("Test %0d line %0d: o_traceReady was high before the line could be traced",
                 curTest, curLine);
        errors++;
        testErrors++;
      end
      // The next line starts in the same edge, so ready must already be gone
      if (acceptSeen && i_traceReady) begin
        $display("Test %0d line %0d: o_traceReady stayed high after an accepted strobe",
                 curTest, curLine);
        errors++;
        testErrors++;
      end
    end
    if (timeoutSeen) begin
      $display("Test %0d line %0d: the tracer never became ready, gave up waiting",
               curTest, curLine);
      errors++;
      testErrors++;
    end
    if (endSeen) begin
      $display("Test %0d finished: %0d checks, %0d errors", curTest, testChecks, testErrors);
      testChecks = 0;
      testErrors = 0;
    end
    if (reportSeen) begin
      $display("Total checks %0d, total errors %0d", checks, errors);
    end
  end

endmodule

// ==== logic/tracerTop.sv ====
`timescale 1ns/1ns

module tracerTop #(
  parameter int                   MapBits = 4,
  parameter int                   StartOffset = 272,
  parameter fixedPointPkg::fixedT MinDist = fixedPointPkg::fixedT'(1 << (fixedPointPkg::FracBits - 3))
) (
  input  logic                  clk,
  input  logic                  do_reset,
  input  logic                  i_vsync,
  input  logic                  i_hmax,
  input  fixedPointPkg::cameraT i_camera,
  input  logic [1:0]            i_mapVal,
  output logic [MapBits-1:0]    o_mapCol,
  output logic [MapBits-1:0]    o_mapRow,
  output logic                  o_traceReady,
  output tracerPkg::lineResultT o_line
);

  // Ray state from the camera block
  fixedPointPkg::vecT   rayDir;
  fixedPointPkg::vecT   player;
  logic                 nextLine;
  // Reciprocal handshake
  logic                 req;
  logic                 ack;
  fixedPointPkg::fixedT operand;
  fixedPointPkg::fixedT rcpResult;
  // Walker command and results
  tracerPkg::walkOpT    op;
  fixedPointPkg::fixedT stepX;
  fixedPointPkg::fixedT stepY;
  logic                 hit;
  fixedPointPkg::fixedT wallDist;
  logic [1:0]           wall;
  logic                 side;
  logic [5:0]           texU;

  cameraRegs #(
    .StartOffset(StartOffset)
  ) uCameraRegs (
    .clk       (clk),
    .do_reset  (do_reset),
    .i_vsync   (i_vsync),
    .i_camera  (i_camera),
    .i_nextLine(nextLine),
    .o_rayDir  (rayDir),
    .o_player  (player)
  );

  reciprocalUnit uReciprocal (
    .clk      (clk),
    .do_reset (do_reset),
    .i_req    (req),
    .i_operand(operand),
    .o_ack    (ack),
    .o_result (rcpResult)
  );

  gridWalker #(
    .MapBits(MapBits),
    .MinDist(MinDist)
  ) uGridWalker (
    .clk       (clk),
    .do_reset  (do_reset),
    .i_op      (op),
    .i_stepX   (stepX),
    .i_stepY   (stepY),
    .i_rayDir  (rayDir),
    .i_player  (player),
    .i_mapVal  (i_mapVal),
    .o_mapCol  (o_mapCol),
    .o_mapRow  (o_mapRow),
    .o_hit     (hit),
    .o_wallDist(wallDist),
    .o_wall    (wall),
    .o_side    (side),
    .o_texU    (texU)
  );

  traceControl uTraceControl (
    .clk         (clk),
    .do_reset    (do_reset),
    .i_vsync     (i_vsync),
    .i_hmax      (i_hmax),
    .i_rayDir    (rayDir),
    .i_ack       (ack),
    .i_rcpResult (rcpResult),
    .i_hit       (hit),
    .i_wallDist  (wallDist),
    .i_wall      (wall),
    .i_side      (side),
    .i_texU      (texU),
    .o_req       (req),
    .o_operand   (operand),
    .o_op        (op),
    .o_stepX     (stepX),
    .o_stepY     (stepY),
    .o_nextLine  (nextLine),
    .o_traceReady(o_traceReady),
    .o_line      (o_line)
  );

endmodule

// ==== logic/traceControl.sv ====
`timescale 1ns/1ns

module traceControl (
  input  logic                  clk,
  input  logic                  do_reset,
  input  logic                  i_vsync,
  input  logic                  i_hmax,
  input  fixedPointPkg::vecT    i_rayDir,
  input  logic                  i_ack,
  input  fixedPointPkg::fixedT  i_rcpResult,
  input  logic                  i_hit,
  input  fixedPointPkg::fixedT  i_wallDist,
  input  logic [1:0]            i_wall,
  input  logic                  i_side,
  input  logic [5:0]            i_texU,
  output logic                  o_req,
  output fixedPointPkg::fixedT  o_operand,
  output tracerPkg::walkOpT     o_op,
  output fixedPointPkg::fixedT  o_stepX,
  output fixedPointPkg::fixedT  o_stepY,
  output logic                  o_nextLine,
  output logic                  o_traceReady,
  output tracerPkg::lineResultT o_line
);

  // Reciprocal of distance has FracBits fraction bits, size keeps eight of them
  localparam int SizeShift = fixedPointPkg::FracBits - 8;
  localparam logic [10:0] SizeMax = 11'd2047;

  tracerPkg::traceStateT state;
  fixedPointPkg::fixedT  sizeFull;
  logic [10:0]           sizeClamped;
  logic [10:0]           size;
  logic                  isRcpState;
  logic                  rcpDone;
  logic                  lineStrobe;

  always_comb begin
    // Operand follows the state so it holds steady while req is high
    case (state)
      tracerPkg::RcpX: o_operand = i_rayDir.x;
      tracerPkg::RcpY: o_operand = i_rayDir.y;
      default:         o_operand = i_wallDist;
    endcase

    case (state)
      tracerPkg::InitX: o_op = tracerPkg::OpInitX;
      tracerPkg::InitY: o_op = tracerPkg::OpInitY;
      tracerPkg::Walk:  o_op = tracerPkg::OpStep;
      tracerPkg::TexU:  o_op = tracerPkg::OpTexU;
      default:          o_op = tracerPkg::OpIdle;
    endcase

    isRcpState = state == tracerPkg::RcpX || state == tracerPkg::RcpY
                 || state == tracerPkg::RcpSize;

    sizeFull = i_rcpResult >>> SizeShift;
    if (sizeFull > fixedPointPkg::fixedT'(SizeMax)) begin
      sizeClamped = SizeMax;
    end else begin
      sizeClamped = sizeFull[10:0];
    end
  end

  // Result is sampled in the cycle where req and ack are both high
  assign rcpDone = o_req && i_ack;
  assign o_traceReady = state == tracerPkg::Done && !i_vsync;
  // Strobe while ready presents the line and moves the ray in the same edge
  assign lineStrobe = o_traceReady && i_hmax;
  assign o_nextLine = lineStrobe;

  always_ff @(posedge clk) begin
    if (do_reset || i_vsync) begin
      // Vsync holds the sequence at the first step of a new frame
      state <= tracerPkg::RcpX;
      o_req <= 1'b0;
    end else begin
      // Req only rises after ack from the previous exchange has fallen
      if (rcpDone) begin
        o_req <= 1'b0;
      end else if (isRcpState && !o_req && !i_ack) begin
        o_req <= 1'b1;
      end

      case (state)
        tracerPkg::RcpX: begin
          if (rcpDone) begin
            state <= tracerPkg::RcpY;
          end
        end
        tracerPkg::RcpY: begin
          if (rcpDone) begin
            state <= tracerPkg::InitX;
          end
        end
        tracerPkg::InitX: state <= tracerPkg::InitY;
        tracerPkg::InitY: state <= tracerPkg::Walk;
        tracerPkg::Walk: begin
          if (i_hit) begin
            state <= tracerPkg::RcpSize;
          end
        end
        tracerPkg::RcpSize: begin
          if (rcpDone) begin
            state <= tracerPkg::TexU;
          end
        end
        tracerPkg::TexU: state <= tracerPkg::Done;
        tracerPkg::Done: begin
          if (i_hmax) begin
            state <= tracerPkg::RcpX;
          end
        end
        default: state <= tracerPkg::RcpX;
      endcase
    end
  end

  // Step distances and size only change when a reciprocal result arrives
  always_ff @(posedge clk) begin
    if (rcpDone) begin
      case (state)
        tracerPkg::RcpX: o_stepX <= i_rcpResult;
        tracerPkg::RcpY: o_stepY <= i_rcpResult;
        default:         size <= sizeClamped;
      endcase
    end
  end

  // The displayed line keeps its old value until a strobe finds a ready result
  always_ff @(posedge clk) begin
    if (do_reset) begin
      o_line <= '0;
    end else if (lineStrobe) begin
      o_line.wall <= i_wall;
      o_line.side <= i_side;
      o_line.size <= size;
      o_line.texU <= i_texU;
    end
  end

endmodule

// ==== logic/gridWalker.sv ====
`timescale 1ns/1ns

module gridWalker #(
  parameter int                   MapBits = 4,
  parameter fixedPointPkg::fixedT MinDist = fixedPointPkg::fixedT'(1 << (fixedPointPkg::FracBits - 3))
) (
  input  logic                 clk,
  input  logic                 do_reset,
  input  tracerPkg::walkOpT    i_op,
  input  fixedPointPkg::fixedT i_stepX,
  input  fixedPointPkg::fixedT i_stepY,
  input  fixedPointPkg::vecT   i_rayDir,
  input  fixedPointPkg::vecT   i_player,
  input  logic [1:0]           i_mapVal,
  output logic [MapBits-1:0]   o_mapCol,
  output logic [MapBits-1:0]   o_mapRow,
  output logic                 o_hit,
  output fixedPointPkg::fixedT o_wallDist,
  output logic [1:0]           o_wall,
  output logic                 o_side,
  output logic [5:0]           o_texU
);

  localparam int FracBits = fixedPointPkg::FracBits;
  localparam int IntBits = fixedPointPkg::IntBits;
  localparam int Width = fixedPointPkg::Width;

  // Map cell under test and the cell the player stands in
  logic [IntBits-1:0]    mapX;
  logic [IntBits-1:0]    mapY;
  logic [IntBits-1:0]    playerMapX;
  logic [IntBits-1:0]    playerMapY;
  // Distance along the ray to the next X and Y grid lines
  fixedPointPkg::ufixedT trackX;
  fixedPointPkg::ufixedT trackY;
  fixedPointPkg::fixedT  fracX;
  fixedPointPkg::fixedT  fracY;
  fixedPointPkg::fixedT  partialX;
  fixedPointPkg::fixedT  partialY;
  fixedPointPkg::fixedT  mulA;
  fixedPointPkg::fixedT  mulB;
  fixedPointPkg::fixedT  mulOut;
  fixedPointPkg::fixedT  texSum;
  fixedPointPkg::wideT   product;
  logic                  rayXPos;
  logic                  rayYPos;
  logic                  needStepX;
  logic                  hitNow;
  logic                  mirror;

  assign playerMapX = i_player.x[FracBits +: IntBits];
  assign playerMapY = i_player.y[FracBits +: IntBits];
  assign o_mapCol = mapX[MapBits-1:0];
  assign o_mapRow = mapY[MapBits-1:0];

  always_comb begin
    fracX = fixedPointPkg::fixedT'(i_player.x[FracBits-1:0]);
    fracY = fixedPointPkg::fixedT'(i_player.y[FracBits-1:0]);
    rayXPos = i_rayDir.x > 0;
    rayYPos = i_rayDir.y > 0;
    // Part of the first cell still ahead of the player on each axis
    partialX = rayXPos ? fixedPointPkg::One - fracX : fracX;
    partialY = rayYPos ? fixedPointPkg::One - fracY : fracY;

    // One multiplier serves both track seeds and the texture coordinate
    case (i_op)
      tracerPkg::OpInitX: begin
        mulA = i_stepX;
        mulB = partialX;
      end
      tracerPkg::OpInitY: begin
        mulA = i_stepY;
        mulB = partialY;
      end
      default: begin
        // The hit position runs along the axis that the wall face does not cross
        mulA = o_side ? i_rayDir.x : i_rayDir.y;
        mulB = o_wallDist;
      end
    endcase
    product = mulA * mulB;
    mulOut = product[FracBits +: Width];

    texSum = mulOut + (o_side ? i_player.x : i_player.y);
    // Keep textures reading the same way on opposite faces
    mirror = o_side ? rayYPos : !rayXPos;

    // Ties step along Y
    needStepX = trackX < trackY;
    // Walls inside the player cell or too close would overflow the size
    hitNow = (i_mapVal != 2'd0)
             && (fixedPointPkg::ufixedT'(o_wallDist) >= fixedPointPkg::ufixedT'(MinDist))
             && !(mapX == playerMapX && mapY == playerMapY);
  end

  always_ff @(posedge clk) begin
    if (do_reset) begin
      o_hit <= 1'b0;
    end else if (i_op == tracerPkg::OpInitX) begin
      o_hit <= 1'b0;
    end else if (i_op == tracerPkg::OpStep && hitNow) begin
      o_hit <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    case (i_op)
      tracerPkg::OpInitX: begin
        trackX <= mulOut;
        mapX <= playerMapX;
        mapY <= playerMapY;
        o_wallDist <= '0;
      end
      tracerPkg::OpInitY: begin
        trackY <= mulOut;
      end
      tracerPkg::OpStep: begin
        // Once a hit is found the walk freezes until the next line
        if (!o_hit) begin
          if (hitNow) begin
            o_wall <= i_mapVal;
          end else if (needStepX) begin
            mapX <= rayXPos ? mapX + 1'b1 : mapX - 1'b1;
            trackX <= trackX + fixedPointPkg::ufixedT'(i_stepX);
            o_wallDist <= fixedPointPkg::fixedT'(trackX);
            o_side <= 1'b0;
          end else begin
            mapY <= rayYPos ? mapY + 1'b1 : mapY - 1'b1;
            trackY <= trackY + fixedPointPkg::ufixedT'(i_stepY);
            o_wallDist <= fixedPointPkg::fixedT'(trackY);
            o_side <= 1'b1;
          end
        end
      end
      tracerPkg::OpTexU: begin
        // Top six fractional bits pick the texture column
        o_texU <= texSum[FracBits-1 -: 6] ^ {6{mirror}};
      end
      default: begin
      end
    endcase
  end

endmodule

// ==== logic/reciprocalUnit.sv ====
`timescale 1ns/1ns

module reciprocalUnit (
  input  logic                 clk,
  input  logic                 do_reset,
  input  logic                 i_req,
  input  fixedPointPkg::fixedT i_operand,
  output logic                 o_ack,
  output fixedPointPkg::fixedT o_result
);

  localparam int Width = fixedPointPkg::Width;
  // The numerator is a single one at this bit position
  localparam int TopBit = 2 * fixedPointPkg::FracBits;
  localparam int QuotBits = TopBit + 1;
  localparam int CountBits = $clog2(QuotBits);

  logic                  busy;
  logic [CountBits-1:0]  bitCount;
  fixedPointPkg::ufixedT divisor;
  fixedPointPkg::ufixedT remainder;
  fixedPointPkg::ufixedT absOperand;
  logic [QuotBits-1:0]   quotient;
  logic [Width:0]        trial;
  logic [Width:0]        diff;
  logic                  trialFits;
  logic                  overflow;
  logic                  start;

  always_comb begin
    // Negating the most negative value still gives its magnitude as unsigned
    if (i_operand[Width-1]) begin
      absOperand = fixedPointPkg::ufixedT'(-i_operand);
    end else begin
      absOperand = fixedPointPkg::ufixedT'(i_operand);
    end
    // Only the first iteration brings a one down from the numerator
    trial = {remainder, bitCount == CountBits'(TopBit)};
    diff = trial - {1'b0, divisor};
    trialFits = trial >= {1'b0, divisor};
  end

  // A new division only starts once the previous handshake has closed
  assign start = i_req && !busy && !o_ack;

  always_ff @(posedge clk) begin
    if (do_reset) begin
      busy <= 1'b0;
      o_ack <= 1'b0;
      bitCount <= '0;
    end else if (busy) begin
      // Dropping req early abandons the division
      if (!i_req) begin
        busy <= 1'b0;
      end else begin
        if (bitCount == '0) begin
          busy <= 1'b0;
          o_ack <= 1'b1;
        end
        bitCount <= bitCount - 1'b1;
      end
    end else if (o_ack) begin
      // Ack follows req back down to close the four-phase cycle
      if (!i_req) begin
        o_ack <= 1'b0;
      end
    end else if (start) begin
      busy <= 1'b1;
      bitCount <= CountBits'(TopBit);
    end
  end

  // Restoring shift-subtract datapath, one quotient bit per cycle
  always_ff @(posedge clk) begin
    if (start) begin
      divisor <= absOperand;
      remainder <= '0;
      quotient <= '0;
    end else if (busy) begin
      remainder <= trialFits ? diff[Width-1:0] : trial[Width-1:0];
      quotient <= {quotient[QuotBits-2:0], trialFits};
    end
  end

  // A zero divisor fills the quotient with ones, so it lands here as well
  assign overflow = |quotient[QuotBits-1:Width-1];

  // Quotient stays frozen while ack is high, so the result holds with it
  assign o_result = overflow ? fixedPointPkg::MaxFixed : {1'b0, quotient[Width-2:0]};

endmodule

// ==== logic/cameraRegs.sv ====
`timescale 1ns/1ns

module cameraRegs #(
  parameter int StartOffset = 272
) (
  input  logic                  clk,
  input  logic                  do_reset,
  input  logic                  i_vsync,
  input  fixedPointPkg::cameraT i_camera,
  input  logic                  i_nextLine,
  output fixedPointPkg::vecT    o_rayDir,
  output fixedPointPkg::vecT    o_player
);

  // The addend counts whole plane vectors, so it is scaled back down here
  localparam int AddendShift = 8;

  // Camera frozen at frame start so the whole frame sees one viewpoint
  fixedPointPkg::cameraT camera;
  // Ray deflection from the facing vector, accumulated one plane per line
  fixedPointPkg::vecT addend;

  always_ff @(posedge clk) begin
    if (do_reset) begin
      camera <= '0;
      addend <= '0;
    end else if (i_vsync) begin
      camera <= i_camera;
      // First line starts StartOffset plane steps before the centre line
      addend.x <= fixedPointPkg::fixedT'(-(i_camera.plane.x * StartOffset));
      addend.y <= fixedPointPkg::fixedT'(-(i_camera.plane.y * StartOffset));
    end else if (i_nextLine) begin
      // Move the ray one line across the view plane
      addend.x <= addend.x + camera.plane.x;
      addend.y <= addend.y + camera.plane.y;
    end
  end

  // Accumulating a full plane per line keeps precision, the shift restores the scale
  assign o_rayDir.x = camera.facing.x + (addend.x >>> AddendShift);
  assign o_rayDir.y = camera.facing.y + (addend.y >>> AddendShift);

  assign o_player = camera.player;

endmodule

// ==== logic/tracerPkg.sv ====
package tracerPkg;

  // Per-line tracer sequence
  typedef enum logic [2:0] {
    // Reciprocal of each ray component gives the step distances
    RcpX,
    RcpY,
    // The walker seeds its track distances, one axis per cycle
    InitX,
    InitY,
    // Grid walk until a valid hit
    Walk,
    // Reciprocal of the wall distance gives the wall size
    RcpSize,
    // Shared multiplier forms the texture coordinate
    TexU,
    // Result is ready and waits for the line strobe
    Done
  } traceStateT;

  // Commands from the sequencer to the grid walker
  typedef enum logic [2:0] {
    OpIdle,
    OpInitX,
    OpInitY,
    OpStep,
    OpTexU
  } walkOpT;

  // Trace result for one line as seen by the display
  typedef struct packed {
    logic [1:0]  wall;
    logic        side;
    logic [10:0] size;
    logic [5:0]  texU;
  } lineResultT;

endpackage

// ==== logic/fixedPointPkg.sv ====
package fixedPointPkg;

  // Fractional bits in every fixed-point value
  localparam int FracBits = 10;
  // Integer bits with the sign bit counted in
  localparam int IntBits = 8;
  localparam int Width = IntBits + FracBits;

  // Signed Q8.10 number used for positions, vectors and distances
  typedef logic signed [Width-1:0] fixedT;
  // Track distances can grow past the signed range, so they compare as unsigned
  typedef logic [Width-1:0] ufixedT;
  // Full product of two fixedT operands
  typedef logic signed [2*Width-1:0] wideT;

  // One in fixed point, and the largest positive value for saturation
  localparam fixedT One = fixedT'(1 << FracBits);
  localparam fixedT MaxFixed = {1'b0, {(Width-1){1'b1}}};

  typedef struct packed {
    fixedT x;
    fixedT y;
  } vecT;

  // Everything the tracer needs to know about the viewer for one frame
  typedef struct packed {
    vecT player;
    vecT facing;
    vecT plane;
  } cameraT;

endpackage
